//--- audio_pkg.sv
package audio_pkg;

    ////////////////////////////////////////
    // sizes and rates
    ////////////////////////////////////////
    localparam int PCM_WIDTH      = 24;        // sample bits
    localparam int SLOT_BITS      = 32;        // bclks per half-frame
    localparam int BCLK_DIV       = 4;         // clk cycles per half dac bclk
    localparam int GAIN_FRAC_BITS = 14;
    localparam int GAIN_UNITY     = 16384;     // 1.0 in gain units

    // signed sample limits
    localparam int PCM_MAX = (1 << (PCM_WIDTH - 1)) - 1;
    localparam int PCM_MIN = -(1 << (PCM_WIDTH - 1));

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef logic signed [PCM_WIDTH-1:0] pcm_sample_t;

    // unsigned 2.14 fixed point
    typedef logic [15:0] gain_t;

    // one stereo sample with its strobe
    typedef struct packed {
        logic        valid;
        pcm_sample_t left;
        pcm_sample_t right;
    } stereo_pcm_t;

    // output source, audio_control[2:1]
    typedef enum logic [1:0] {
        MUX_BYPASS   = 2'd0,
        MUX_GAIN     = 2'd1,
        MUX_TRIANGLE = 2'd2,
        MUX_MUTE     = 2'd3
    } mux_sel_e;

    typedef enum logic {
        TX_IDLE = 1'b0,
        TX_RUN  = 1'b1
    } tx_state_e;

    // gain write target, audio_control[3]
    typedef enum logic {
        CHAN_LEFT  = 1'b0,
        CHAN_RIGHT = 1'b1
    } chan_sel_e;

endpackage

//--- i2s_to_pcm.sv
`timescale 1ns/100ps

module i2s_to_pcm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,        // audio enable
    input  logic                   bclk,       // async, slower than clk
    input  logic                   lrclk,
    input  logic                   i2s_data,
    output audio_pkg::stereo_pcm_t rx_pair,
    output logic [7:0]             bit_cnt     // bclks in last half-frame
);

    logic [1:0]             bclk_s;     // 2-flop synchronizers
    logic [1:0]             lr_s;
    logic [1:0]             data_s;
    logic                   bclk_d;     // for edge detect
    logic                   lr_prev;    // lrclk at previous bclk rise
    logic                   bclk_rise;
    logic                   slot_end;
    logic [7:0]             bits_cnt;   // bits so far in current slot
    logic                   close_d1;
    logic                   close_d2;
    audio_pkg::pcm_sample_t l_shift;
    audio_pkg::pcm_sample_t r_shift;

    ////////////////////////////////////////
    // synchronize and find bclk edges
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_s <= '0;
            lr_s   <= '0;
            data_s <= '0;
            bclk_d <= 1'b0;
        end else begin
            bclk_s <= {bclk_s[0], bclk};
            lr_s   <= {lr_s[0], lrclk};
            data_s <= {data_s[0], i2s_data};
            bclk_d <= bclk_s[1];
        end
    end

    assign bclk_rise = bclk_s[1] & ~bclk_d;
    // lrclk moved one bit earlier so this bit is the last of the old slot
    assign slot_end  = bclk_rise && (lr_s[1] != lr_prev);

    // bit count per half-frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lr_prev  <= 1'b0;
            bits_cnt <= '0;
            bit_cnt  <= '0;
        end else if (bclk_rise) begin
            lr_prev <= lr_s[1];
            if (slot_end) begin
                bits_cnt <= '0;
                bit_cnt  <= bits_cnt + 8'd1;   // closing bit counts too
            end else begin
                bits_cnt <= bits_cnt + 8'd1;
            end
        end
    end

    // keep only the top 24 bits of each slot
    always_ff @(posedge clk) begin
        if (bclk_rise && bits_cnt < audio_pkg::PCM_WIDTH) begin
            if (lr_prev)
                r_shift <= {r_shift[audio_pkg::PCM_WIDTH-2:0], data_s[1]};
            else
                l_shift <= {l_shift[audio_pkg::PCM_WIDTH-2:0], data_s[1]};
        end
    end

    ////////////////////////////////////////
    // output pair
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            close_d1      <= 1'b0;
            close_d2      <= 1'b0;
            rx_pair.valid <= 1'b0;
        end else begin
            close_d1      <= slot_end & lr_prev;  // right slot just ended
            close_d2      <= close_d1;
            rx_pair.valid <= close_d2 & run;
        end
        if (close_d2) begin
            rx_pair.left  <= l_shift;
            rx_pair.right <= r_shift;
        end
    end

    // one strobe per stereo frame
    a_single_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rx_pair.valid |=> !rx_pair.valid);

endmodule

//--- channel_gain.sv
`timescale 1ns/100ps

module channel_gain (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   gain_wr_en,     // cpu strobe
    input  audio_pkg::chan_sel_e   gain_sel,
    input  audio_pkg::gain_t       gain_wr_data,
    input  audio_pkg::stereo_pcm_t in_pair,
    output audio_pkg::stereo_pcm_t out_pair
);

    audio_pkg::gain_t                    gain_l;
    audio_pkg::gain_t                    gain_r;
    logic                                s1_valid;
    logic signed [audio_pkg::PCM_WIDTH+16:0] prod_l;   // 24 x 17 signed
    logic signed [audio_pkg::PCM_WIDTH+16:0] prod_r;

    // drop fraction bits and clamp to the sample range
    function automatic audio_pkg::pcm_sample_t saturate(
        input logic signed [audio_pkg::PCM_WIDTH+16:0] p
    );
        logic signed [audio_pkg::PCM_WIDTH+16:0] s;
        s = p >>> audio_pkg::GAIN_FRAC_BITS;   // arithmetic, keeps sign
        if (s > audio_pkg::PCM_MAX)
            s = audio_pkg::PCM_MAX;
        else if (s < audio_pkg::PCM_MIN)
            s = audio_pkg::PCM_MIN;
        return s[audio_pkg::PCM_WIDTH-1:0];
    endfunction

    ////////////////////////////////////////
    // gain registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gain_l <= audio_pkg::gain_t'(audio_pkg::GAIN_UNITY);
            gain_r <= audio_pkg::gain_t'(audio_pkg::GAIN_UNITY);
        end else if (gain_wr_en) begin
            if (gain_sel == audio_pkg::CHAN_RIGHT)
                gain_r <= gain_wr_data;
            else
                gain_l <= gain_wr_data;
        end
    end

    ////////////////////////////////////////
    // stage 1 multiply
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= in_pair.valid;
        // gain zero-extended so it stays positive
        prod_l <= $signed(in_pair.left) * $signed({1'b0, gain_l});
        prod_r <= $signed(in_pair.right) * $signed({1'b0, gain_r});
    end

    ////////////////////////////////////////
    // stage 2 shift and saturate
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n)
            out_pair.valid <= 1'b0;
        else
            out_pair.valid <= s1_valid;
        out_pair.left  <= saturate(prod_l);
        out_pair.right <= saturate(prod_r);
    end

    // fixed two-cycle latency, back to back pairs allowed
    a_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        out_pair.valid == $past(in_pair.valid, 2));

endmodule

//--- triangle_gen.sv
`timescale 1ns/100ps

module triangle_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic [7:0]             inc,          // cpu step, scaled by 256
    input  logic                   frame_load,   // from the serializer
    output audio_pkg::stereo_pcm_t tri_pair
);

    audio_pkg::pcm_sample_t              phase;
    logic                                rising;
    logic                                tri_valid;
    logic signed [audio_pkg::PCM_WIDTH:0] step;    // one extra bit for overflow
    logic signed [audio_pkg::PCM_WIDTH:0] up_val;
    logic signed [audio_pkg::PCM_WIDTH:0] dn_val;

    assign step   = $signed({{(audio_pkg::PCM_WIDTH - 15){1'b0}}, inc, 8'd0});
    assign up_val = phase + step;
    assign dn_val = phase - step;

    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            phase     <= '0;
            rising    <= 1'b1;
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= frame_load;
            if (frame_load) begin
                if (rising) begin
                    if (up_val > audio_pkg::PCM_MAX) begin
                        rising <= 1'b0;            // turn at the top
                        phase  <= dn_val[audio_pkg::PCM_WIDTH-1:0];
                    end else begin
                        phase  <= up_val[audio_pkg::PCM_WIDTH-1:0];
                    end
                end else begin
                    if (dn_val < audio_pkg::PCM_MIN) begin
                        rising <= 1'b1;            // turn at the bottom
                        phase  <= up_val[audio_pkg::PCM_WIDTH-1:0];
                    end else begin
                        phase  <= dn_val[audio_pkg::PCM_WIDTH-1:0];
                    end
                end
            end
        end
    end

    // same wave on both channels
    assign tri_pair = '{valid: tri_valid, left: phase, right: phase};

endmodule

//--- audio_mux.sv
`timescale 1ns/100ps

module audio_mux (
    input  logic                   clk,
    input  logic                   rst_n,
    input  audio_pkg::mux_sel_e    sel,
    input  audio_pkg::stereo_pcm_t rx_pair,     // straight from the receiver
    input  audio_pkg::stereo_pcm_t gain_pair,
    input  audio_pkg::stereo_pcm_t tri_pair,
    output audio_pkg::stereo_pcm_t mux_pair
);

    audio_pkg::stereo_pcm_t src;

    always_comb begin
        case (sel)
            audio_pkg::MUX_BYPASS:   src = rx_pair;
            audio_pkg::MUX_GAIN:     src = gain_pair;
            audio_pkg::MUX_TRIANGLE: src = tri_pair;
            // mute keeps the input frame rate
            default:                 src = '{valid: rx_pair.valid, left: '0, right: '0};
        endcase
    end

    // one register stage on every path
    always_ff @(posedge clk) begin
        if (!rst_n)
            mux_pair.valid <= 1'b0;
        else
            mux_pair.valid <= src.valid;
        mux_pair.left  <= src.left;
        mux_pair.right <= src.right;
    end

endmodule

//--- pcm_to_i2s.sv
`timescale 1ns/100ps

module pcm_to_i2s (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  audio_pkg::stereo_pcm_t in_pair,
    output logic                   frame_load,   // pulse at each frame start
    output logic                   bclk,
    output logic                   lrclk,
    output logic                   s_data
);

    audio_pkg::tx_state_e                           state;
    audio_pkg::pcm_sample_t                         hold_l;   // latest pair
    audio_pkg::pcm_sample_t                         hold_r;
    logic [$clog2(audio_pkg::BCLK_DIV)-1:0]         div_cnt;
    logic [$clog2(2 * audio_pkg::SLOT_BITS)-1:0]    slot_cnt; // bit position in frame
    logic [2*audio_pkg::SLOT_BITS-1:0]              shift;
    logic [2*audio_pkg::SLOT_BITS-1:0]              frame;
    logic [2*audio_pkg::SLOT_BITS-1:0]              next_bits;
    logic                                           tick;
    logic                                           fall;

    // newer pair overwrites an unsent one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_l <= '0;
            hold_r <= '0;
        end else if (in_pair.valid) begin
            hold_l <= in_pair.left;
            hold_r <= in_pair.right;
        end
    end

    ////////////////////////////////////////
    // frame layout and bit clock
    ////////////////////////////////////////
    // one pad bit ahead of each msb, zeros after each lsb
    assign frame = {1'b0, hold_l, {(audio_pkg::SLOT_BITS - audio_pkg::PCM_WIDTH){1'b0}},
                    hold_r, {(audio_pkg::SLOT_BITS - audio_pkg::PCM_WIDTH - 1){1'b0}}};

    assign tick      = (state == audio_pkg::TX_RUN) && (div_cnt == audio_pkg::BCLK_DIV - 1);
    assign fall      = tick & bclk;             // bclk about to go low
    assign next_bits = (slot_cnt == '0) ? frame : shift;

    always_ff @(posedge clk) begin
        if (fall)
            shift <= next_bits << 1;
    end

    ////////////////////////////////////////
    // serializer FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= audio_pkg::TX_IDLE;
            div_cnt    <= '0;
            slot_cnt   <= '0;
            bclk       <= 1'b0;
            lrclk      <= 1'b0;
            s_data     <= 1'b0;
            frame_load <= 1'b0;
        end else begin
            frame_load <= 1'b0;
            case (state)
                audio_pkg::TX_IDLE: begin
                    if (run)
                        state <= audio_pkg::TX_RUN;
                end
                audio_pkg::TX_RUN: begin
                    if (!run) begin
                        state    <= audio_pkg::TX_IDLE;
                        div_cnt  <= '0;
                        slot_cnt <= '0;
                        bclk     <= 1'b0;   // park everything low
                        lrclk    <= 1'b0;
                        s_data   <= 1'b0;
                    end else begin
                        div_cnt <= tick ? '0 : div_cnt + 1'b1;
                        if (tick)
                            bclk <= ~bclk;
                        if (fall) begin
                            slot_cnt   <= slot_cnt + 1'b1;
                            lrclk      <= slot_cnt[$high(slot_cnt)];  // high for right half
                            s_data     <= next_bits[$high(next_bits)];
                            frame_load <= (slot_cnt == '0);
                        end
                    end
                end
                default: state <= audio_pkg::TX_IDLE;
            endcase
        end
    end

    // DAC samples on rising bclk so data moves only on the fall
    a_fall_only: assert property (@(posedge clk) disable iff (!rst_n || !run)
        ($changed(lrclk) || $changed(s_data)) |-> $fell(bclk));

endmodule

//--- audio_processing.sv
`timescale 1ns/100ps

module audio_processing (
    input  logic       clk,
    input  logic       rst_n,
    // i2s from the codec
    input  logic       i2s_bclk,
    input  logic       i2s_lrclk,
    input  logic       i2s_d,
    // cpu registers
    input  logic [7:0] audio_control,   // bits 7:4 reserved
    input  logic       gain_wr_en,
    input  logic [7:0] gain_wr_lsb,
    input  logic [7:0] gain_wr_msb,
    input  logic [7:0] triangle_inc,
    // dac side
    output logic       audio_enable,
    output logic       dac_bclk,
    output logic       dac_lrclk,
    output logic       dac_data,
    output logic [7:0] i2s_bit_cnt
);

    audio_pkg::mux_sel_e    mux_sel;
    audio_pkg::chan_sel_e   gain_sel;
    audio_pkg::gain_t       gain_wr_data;
    audio_pkg::stereo_pcm_t rx_pair;
    audio_pkg::stereo_pcm_t gain_pair;
    audio_pkg::stereo_pcm_t tri_pair;
    audio_pkg::stereo_pcm_t mux_pair;
    logic                   frame_load;

    ////////////////////////////////////////
    // control register fields
    ////////////////////////////////////////
    assign audio_enable = audio_control[0];
    assign mux_sel      = audio_pkg::mux_sel_e'(audio_control[2:1]);
    assign gain_sel     = audio_pkg::chan_sel_e'(audio_control[3]);
    assign gain_wr_data = {gain_wr_msb, gain_wr_lsb};

    i2s_to_pcm i2s_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (audio_enable),
        .bclk       (i2s_bclk),
        .lrclk      (i2s_lrclk),
        .i2s_data   (i2s_d),
        .rx_pair    (rx_pair),
        .bit_cnt    (i2s_bit_cnt)
    );

    channel_gain gain0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .gain_wr_en   (gain_wr_en),
        .gain_sel     (gain_sel),
        .gain_wr_data (gain_wr_data),
        .in_pair      (rx_pair),
        .out_pair     (gain_pair)
    );

    triangle_gen tri_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (audio_enable),
        .inc        (triangle_inc),
        .frame_load (frame_load),    // steps once per dac frame
        .tri_pair   (tri_pair)
    );

    audio_mux out_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (mux_sel),
        .rx_pair   (rx_pair),
        .gain_pair (gain_pair),
        .tri_pair  (tri_pair),
        .mux_pair  (mux_pair)
    );

    pcm_to_i2s i2s_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (audio_enable),
        .in_pair    (mux_pair),
        .frame_load (frame_load),
        .bclk       (dac_bclk),
        .lrclk      (dac_lrclk),
        .s_data     (dac_data)
    );

endmodule

//--- audio_processing_tb.sv
`timescale 1ns/100ps

module audio_processing_tb;

    localparam int SRC_HALF   = 4;      // source half bit clock, in clk cycles
    localparam int FRAME_CLKS = 2 * audio_pkg::SLOT_BITS * 2 * audio_pkg::BCLK_DIV;
    localparam int TRI_FRAMES = 420;    // long enough to pass both turns
    localparam audio_pkg::gain_t G_ONE = 16'(audio_pkg::GAIN_UNITY);

    // one stimulus step and its expected dac frame
    typedef struct packed {
        audio_pkg::mux_sel_e    sel;
        audio_pkg::gain_t       gain_l;
        audio_pkg::gain_t       gain_r;
        audio_pkg::pcm_sample_t in_l;
        audio_pkg::pcm_sample_t in_r;
        audio_pkg::pcm_sample_t exp_l;
        audio_pkg::pcm_sample_t exp_r;
    } step_row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       i2s_bclk;
    logic       i2s_lrclk;
    logic       i2s_d;
    logic [7:0] audio_control;
    logic       gain_wr_en;
    logic [7:0] gain_wr_lsb;
    logic [7:0] gain_wr_msb;
    logic [7:0] triangle_inc;
    logic       audio_enable;
    logic       dac_bclk;
    logic       dac_lrclk;
    logic       dac_data;
    logic [7:0] i2s_bit_cnt;

    // dac capture state
    audio_pkg::pcm_sample_t sh_left  = '0;
    audio_pkg::pcm_sample_t sh_right = '0;
    audio_pkg::pcm_sample_t cap_left  = '0;   // last complete frame
    audio_pkg::pcm_sample_t cap_right = '0;
    int                     cap_count = 0;
    int                     cap_bit   = 0;
    logic                   cap_lr_prev = 1'b0;

    step_row_t rows[$];
    int        n_checks    = 0;
    int        n_value_err = 0;
    int        n_other_err = 0;

    always #5 clk = ~clk;

    audio_processing dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i2s_bclk      (i2s_bclk),
        .i2s_lrclk     (i2s_lrclk),
        .i2s_d         (i2s_d),
        .audio_control (audio_control),
        .gain_wr_en    (gain_wr_en),
        .gain_wr_lsb   (gain_wr_lsb),
        .gain_wr_msb   (gain_wr_msb),
        .triangle_inc  (triangle_inc),
        .audio_enable  (audio_enable),
        .dac_bclk      (dac_bclk),
        .dac_lrclk     (dac_lrclk),
        .dac_data      (dac_data),
        .i2s_bit_cnt   (i2s_bit_cnt)
    );

    ////////////////////////////////////////
    // i2s capture on the dac side
    ////////////////////////////////////////
    always @(posedge dac_bclk) begin
        if (dac_lrclk != cap_lr_prev) begin
            cap_bit <= 0;                       // pad bit ahead of the msb
            if (!dac_lrclk) begin               // right slot closed
                cap_left  <= sh_left;
                cap_right <= sh_right;
                cap_count <= cap_count + 1;
            end
        end else begin
            if (cap_bit < audio_pkg::PCM_WIDTH) begin
                if (dac_lrclk)
                    sh_right <= {sh_right[audio_pkg::PCM_WIDTH-2:0], dac_data};
                else
                    sh_left  <= {sh_left[audio_pkg::PCM_WIDTH-2:0], dac_data};
            end
            cap_bit <= cap_bit + 1;
        end
        cap_lr_prev <= dac_lrclk;
    end

    task automatic end_run();
        $display("checks: %0d  value errors: %0d  other errors: %0d",
                 n_checks, n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic check_pcm(input string name, input audio_pkg::pcm_sample_t exp,
                             input audio_pkg::pcm_sample_t got);
        n_checks++;
        if (got !== exp) begin
            n_value_err++;
            $display("FAILED at %0t: %s expected %0d (%06h) got %0d (%06h)",
                     $time, name, exp, exp, got, got);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] exp,
                               input logic [7:0] got);
        n_checks++;
        if (got !== exp) begin
            n_value_err++;
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // x * g, drop 14 fraction bits rounding down, clamp to 24-bit signed
    function automatic audio_pkg::pcm_sample_t scale_sample(input audio_pkg::pcm_sample_t x,
                                                            input audio_pkg::gain_t g);
        longint p;
        p = longint'(x) * longint'(g);
        p = p >>> audio_pkg::GAIN_FRAC_BITS;
        if (p > audio_pkg::PCM_MAX)
            p = audio_pkg::PCM_MAX;
        else if (p < audio_pkg::PCM_MIN)
            p = audio_pkg::PCM_MIN;
        return audio_pkg::pcm_sample_t'(p);
    endfunction

    task automatic add_row(input audio_pkg::mux_sel_e sel, input audio_pkg::gain_t gl,
                           input audio_pkg::gain_t gr, input audio_pkg::pcm_sample_t l,
                           input audio_pkg::pcm_sample_t r);
        step_row_t row;
        row.sel    = sel;
        row.gain_l = gl;
        row.gain_r = gr;
        row.in_l   = l;
        row.in_r   = r;
        case (sel)
            audio_pkg::MUX_GAIN: begin
                row.exp_l = scale_sample(l, gl);
                row.exp_r = scale_sample(r, gr);
            end
            audio_pkg::MUX_MUTE: begin
                row.exp_l = '0;
                row.exp_r = '0;
            end
            default: begin              // bypass passes samples through
                row.exp_l = l;
                row.exp_r = r;
            end
        endcase
        rows.push_back(row);
    endtask

    task automatic write_gain(input audio_pkg::chan_sel_e chan, input audio_pkg::gain_t g);
        @(negedge clk);
        audio_control[3] = chan;
        gain_wr_msb      = g[15:8];
        gain_wr_lsb      = g[7:0];
        gain_wr_en       = 1'b1;
        @(negedge clk);
        gain_wr_en = 1'b0;
    endtask

    ////////////////////////////////////////
    // i2s source, msb one bit after lrclk moves
    ////////////////////////////////////////
    task automatic send_frames(input audio_pkg::pcm_sample_t l,
                               input audio_pkg::pcm_sample_t r, input int n);
        audio_pkg::pcm_sample_t word;
        int                     pos;
        for (int f = 0; f < n; f++) begin
            for (int b = 0; b < 2 * audio_pkg::SLOT_BITS; b++) begin
                pos  = b % audio_pkg::SLOT_BITS;
                word = (b < audio_pkg::SLOT_BITS) ? l : r;
                @(negedge clk);
                i2s_bclk  = 1'b0;
                i2s_lrclk = (b >= audio_pkg::SLOT_BITS);   // high for right
                i2s_d     = (pos >= 1 && pos <= audio_pkg::PCM_WIDTH) ?
                            word[audio_pkg::PCM_WIDTH - pos] : 1'b0;
                repeat (SRC_HALF - 1) @(negedge clk);
                @(negedge clk);
                i2s_bclk = 1'b1;
                repeat (SRC_HALF - 1) @(negedge clk);
            end
        end
    endtask

    // wait for n more complete dac frames
    task automatic wait_frames(input int n);
        int start;
        int cycles;
        start  = cap_count;
        cycles = 0;
        while (cap_count < start + n && cycles < n * FRAME_CLKS * 2 + 100) begin
            @(negedge clk);
            cycles++;
        end
        if (cap_count < start + n) begin
            n_other_err++;
            $display("timeout at %0t: no complete frame came out of the DAC port", $time);
            end_run();
        end
    endtask

    initial begin
        step_row_t   row;
        int unsigned first_rand;
        int          tri_step;
        int          phase;
        logic        rising;
        int          turns;
        logic        moved;

        first_rand    = $urandom(32'hfb6a86c5);
        rst_n         = 1'b0;
        i2s_bclk      = 1'b0;
        i2s_lrclk     = 1'b0;
        i2s_d         = 1'b0;
        audio_control = 8'h00;
        gain_wr_en    = 1'b0;
        gain_wr_lsb   = 8'h00;
        gain_wr_msb   = 8'h00;
        triangle_inc  = 8'h00;   // triangle parked at zero

        // bypass, sign edges then random
        // gains off unity so a gain-path output would differ
        add_row(audio_pkg::MUX_BYPASS, G_ONE >> 1, 16'd0, 24'h7FFFFF, 24'h800000);
        add_row(audio_pkg::MUX_BYPASS, G_ONE >> 1, 16'd0, 24'h000001, 24'hFFFFFF);
        add_row(audio_pkg::MUX_BYPASS, G_ONE >> 1, 16'd0, 24'h800000, 24'h7FFFFF);
        add_row(audio_pkg::MUX_BYPASS, G_ONE >> 1, 16'd0, 24'(first_rand), 24'($urandom));
        for (int k = 0; k < 2; k++)
            add_row(audio_pkg::MUX_BYPASS, G_ONE >> 1, 16'd0, 24'($urandom), 24'($urandom));
        // gain path
        add_row(audio_pkg::MUX_GAIN, G_ONE, G_ONE, 24'h01E240, 24'hF60445);
        add_row(audio_pkg::MUX_GAIN, G_ONE >> 1, G_ONE >> 1, 24'h400001, 24'hFFFFFD);
        add_row(audio_pkg::MUX_GAIN, 16'd12288, 16'd24576, 24'h100000, 24'hF54322);
        add_row(audio_pkg::MUX_GAIN, 16'hFFFF, 16'hFFFF, 24'h600000, 24'hA00000);
        add_row(audio_pkg::MUX_GAIN, 16'hFFFF, 16'h0000, 24'h7FFFFF, 24'h7FFFFF);
        add_row(audio_pkg::MUX_MUTE, G_ONE, G_ONE, 24'h123456, 24'h654321);

        repeat (16) @(negedge clk);
        rst_n            = 1'b1;
        audio_control[0] = 1'b1;   // enable

        foreach (rows[i]) begin
            row = rows[i];
            write_gain(audio_pkg::CHAN_LEFT, row.gain_l);
            write_gain(audio_pkg::CHAN_RIGHT, row.gain_r);
            audio_control[2:1] = row.sel;
            send_frames(row.in_l, row.in_r, 6);
            wait_frames(2);
            check_pcm($sformatf("row %0d dac_data left", i), row.exp_l, cap_left);
            check_pcm($sformatf("row %0d dac_data right", i), row.exp_r, cap_right);
        end

        check_count("i2s_bit_cnt", 8'd32, i2s_bit_cnt);

        ////////////////////////////////////////
        // triangle, stepped frame by frame
        ////////////////////////////////////////
        triangle_inc       = 8'd255;
        audio_control[2:1] = audio_pkg::MUX_TRIANGLE;
        tri_step           = int'(triangle_inc) << 8;
        wait_frames(4);                  // flush frames loaded before the switch
        phase  = int'(cap_left);
        rising = 1'b1;
        turns  = 0;
        for (int k = 0; k < TRI_FRAMES; k++) begin
            if (rising) begin
                if (phase + tri_step > audio_pkg::PCM_MAX) begin
                    rising = 1'b0;       // top turn
                    turns++;
                    phase  = phase - tri_step;
                end else begin
                    phase  = phase + tri_step;
                end
            end else begin
                if (phase - tri_step < audio_pkg::PCM_MIN) begin
                    rising = 1'b1;
                    turns++;
                    phase  = phase + tri_step;
                end else begin
                    phase  = phase - tri_step;
                end
            end
            wait_frames(1);
            check_pcm("triangle dac_data left", audio_pkg::pcm_sample_t'(phase), cap_left);
            check_pcm("triangle dac_data right", audio_pkg::pcm_sample_t'(phase), cap_right);
        end
        n_checks++;
        if (turns < 2) begin
            n_other_err++;
            $display("triangle run was too short to reach both limits");
        end

        // disabled, dac clocks must stay parked
        audio_control[0] = 1'b0;
        repeat (4) @(negedge clk);
        check_count("audio_enable", 8'd0, {7'd0, audio_enable});
        moved = 1'b0;
        for (int k = 0; k < 2 * FRAME_CLKS; k++) begin
            @(negedge clk);
            if (dac_bclk || dac_lrclk)
                moved = 1'b1;
        end
        n_checks++;
        if (moved) begin
            n_other_err++;
            $display("dac_bclk or dac_lrclk went high while audio_enable was low");
        end

        end_run();
    end

endmodule

//--- audio_processing.f
audio_pkg.sv
i2s_to_pcm.sv
channel_gain.sv
triangle_gen.sv
audio_mux.sv
pcm_to_i2s.sv
audio_processing.sv
audio_processing_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio_processing testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_processing_tb \
    -f audio_processing.f \
    -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
